/* design/cic_data_pkg.sv */
// data path widths and types for the four-channel CIC decimator
// samples, integrator accumulators and scaled results

package cic_data_pkg;

	// raw ADC sample width
	localparam int adc_w = 18;

	// integrator width is adc_w plus 2 * log2(max period of 64)
	localparam int acc_w = 30;

	// width of the scaled, saturated result
	localparam int out_w = 20;

	// channels sharing the serialized back end
	localparam int nchan = 4;

	// all data is two's complement
	typedef logic signed [adc_w-1:0] adc_t;
	typedef logic signed [acc_w-1:0] acc_t;
	typedef logic signed [out_w-1:0] res_t;

endpackage

/* design/cic_ctrl_pkg.sv */
// configuration field widths and types for the CIC decimator
// decimation period, output shift and channel index

package cic_ctrl_pkg;

	// period field with a legal range of 4 to 64
	localparam int period_w = 7;

	// shift field and the fixed offset added to it
	localparam int shift_w = 4;
	localparam logic [shift_w:0] shift_base = (shift_w+1)'(0);

	// channel index wide enough for four channels
	localparam int chan_w = 2;

	typedef logic [period_w-1:0] period_t;
	typedef logic [shift_w-1:0] shift_t;
	typedef logic [chan_w-1:0] chan_t;

endpackage

/* design/decim_timer.sv */
// decimation timer
// down-counter that pulses sample_stb once every period clocks

`timescale 1ns/1ps

module decim_timer import cic_ctrl_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  period_t period,
	output logic    sample_stb
);

	// clocks left in the current run
	period_t count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// count of zero makes the first reload happen right after reset
			count      <= '0;
			sample_stb <= 1'b0;
		end else begin
			if (count == '0) begin
				// reload picks up any new period here and never mid-run
				count      <= period - period_t'(1);
				sample_stb <= 1'b1;
			end else begin
				count      <= count - period_t'(1);
				sample_stb <= 1'b0;
			end
		end
	end

endmodule

/* design/double_integ.sv */
// double integrator for one CIC channel
// two wrapping accumulators plus a snapshot taken on the decimation strobe

`timescale 1ns/1ps

module double_integ import cic_data_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  adc_t sample_in,
	input  logic sample_stb,
	output acc_t snap
);

	// first and second integrator stages
	acc_t acc1;
	acc_t acc2;

	// sign-extended input sample
	acc_t sample_ext;

	assign sample_ext = {{(acc_w-adc_w){sample_in[adc_w-1]}}, sample_in};

	// both stages wrap and the differentiators undo the overflow later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc1 <= '0;
			acc2 <= '0;
		end else begin
			acc1 <= acc1 + sample_ext;
			// second stage sums the first stage's previous value
			acc2 <= acc2 + acc1;
		end
	end

	// snapshot holds acc2 between strobes
	always_ff @(posedge clk) begin
		if (sample_stb) begin
			snap <= acc2;
		end
	end

endmodule

/* design/chan_serializer.sv */
// channel serializer
// after each strobe, emits one snapshot per clock, channel 0 first

`timescale 1ns/1ps

module chan_serializer
	import cic_data_pkg::*;
	import cic_ctrl_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sample_stb,
	input  acc_t [nchan-1:0]  snaps,
	output acc_t              sr_data,
	output logic              sr_valid,
	output chan_t             sr_chan
);

	// burst in progress
	logic busy;

	// channel currently on the output
	chan_t cnt;

	// snapshots are loaded on the strobe edge and stay put for the whole burst,
	// since the next strobe cannot arrive before the burst's last cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else begin
			if (sample_stb) begin
				// start a new burst at channel 0
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + chan_t'(1);
				// last channel ends the burst
				if (cnt == chan_t'(nchan-1)) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// one word per clock out of the snapshot bank
	assign sr_data  = snaps[cnt];
	assign sr_valid = busy;
	assign sr_chan  = cnt;

endmodule

/* design/double_diff.sv */
// two-stage differentiator over the interleaved channel stream
// each channel keeps its own history so the stages act per channel

`timescale 1ns/1ps

module double_diff
	import cic_data_pkg::*;
	import cic_ctrl_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  acc_t  sr_data,
	input  logic  sr_valid,
	input  chan_t sr_chan,
	output acc_t  d_data,
	output logic  d_valid,
	output chan_t d_chan
);

	// last decimated value seen on each channel
	acc_t hist_x [nchan];

	// last first difference on each channel
	acc_t hist_d [nchan];

	// first and second differences of the current word
	acc_t diff1;
	acc_t diff2;

	// wrapping arithmetic cancels integrator overflow
	assign diff1 = sr_data - hist_x[sr_chan];
	assign diff2 = diff1 - hist_d[sr_chan];

	// history only rotates for the channel on the bus
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < nchan; i++) begin
				hist_x[i] <= '0;
				hist_d[i] <= '0;
			end
		end else if (sr_valid) begin
			hist_x[sr_chan] <= sr_data;
			hist_d[sr_chan] <= diff1;
		end
	end

	// one register stage to the scaler
	always_ff @(posedge clk) begin
		d_data <= diff2;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_chan  <= '0;
		end else begin
			d_valid <= sr_valid;
			d_chan  <= sr_chan;
		end
	end

endmodule

/* design/post_scale.sv */
// output scaler
// arithmetic right shift, then saturation to out_w bits with sticky clip

`timescale 1ns/1ps

module post_scale
	import cic_data_pkg::*;
	import cic_ctrl_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  acc_t   d_data,
	input  logic   d_valid,
	input  chan_t  d_chan,
	input  shift_t shift,
	output res_t   result,
	output logic   strobe,
	output chan_t  chan,
	output logic   clip
);

	// total shift, one bit wider to hold the offset
	logic [shift_w:0] full_shift;

	// shift stage registers
	acc_t  sh_data;
	logic  sh_valid;
	chan_t sh_chan;

	// bits above the result msb must all match the sign
	logic in_range;

	assign full_shift = {1'b0, shift} + shift_base;
	assign in_range   = (~|sh_data[acc_w-1:out_w-1]) | (&sh_data[acc_w-1:out_w-1]);

	// first stage does the barrel shift
	always_ff @(posedge clk) begin
		sh_data <= d_data >>> full_shift;
	end

	// second stage clamps to the most positive or most negative result
	always_ff @(posedge clk) begin
		if (in_range) begin
			result <= sh_data[out_w-1:0];
		end else begin
			result <= {sh_data[acc_w-1], {(out_w-1){~sh_data[acc_w-1]}}};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sh_valid <= 1'b0;
			sh_chan  <= '0;
			strobe   <= 1'b0;
			chan     <= '0;
			clip     <= 1'b0;
		end else begin
			sh_valid <= d_valid;
			sh_chan  <= d_chan;
			strobe   <= sh_valid;
			chan     <= sh_chan;
			// clip latches on any saturated word and only reset clears it
			if (sh_valid && !in_range) begin
				clip <= 1'b1;
			end
		end
	end

endmodule

/* design/cic_top.sv */
// four-channel second-order CIC decimator
// integrators, serializer, differentiator and output scaler

`timescale 1ns/1ps

module cic_top
	import cic_data_pkg::*;
	import cic_ctrl_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	// channel 0 in the lowest bits
	input  adc_t [nchan-1:0] adc_data,
	input  period_t          period,
	input  shift_t           shift,
	output res_t             result,
	output chan_t            chan,
	output logic             strobe,
	output logic             clip
);

	// decimation strobe to integrators and serializer
	logic sample_stb;

	// per-channel snapshots
	acc_t [nchan-1:0] snaps;

	// serialized stream
	acc_t  sr_data;
	logic  sr_valid;
	chan_t sr_chan;

	// differentiated stream
	acc_t  d_data;
	logic  d_valid;
	chan_t d_chan;

	decim_timer u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.period     (period),
		.sample_stb (sample_stb)
	);

	// one double integrator per channel
	for (genvar i = 0; i < nchan; i++) begin : g_integ
		double_integ u_integ (
			.clk        (clk),
			.rst_n      (rst_n),
			.sample_in  (adc_data[i]),
			.sample_stb (sample_stb),
			.snap       (snaps[i])
		);
	end

	chan_serializer u_ser (
		.clk        (clk),
		.rst_n      (rst_n),
		.sample_stb (sample_stb),
		.snaps      (snaps),
		.sr_data    (sr_data),
		.sr_valid   (sr_valid),
		.sr_chan    (sr_chan)
	);

	double_diff u_diff (
		.clk      (clk),
		.rst_n    (rst_n),
		.sr_data  (sr_data),
		.sr_valid (sr_valid),
		.sr_chan  (sr_chan),
		.d_data   (d_data),
		.d_valid  (d_valid),
		.d_chan   (d_chan)
	);

	post_scale u_scale (
		.clk     (clk),
		.rst_n   (rst_n),
		.d_data  (d_data),
		.d_valid (d_valid),
		.d_chan  (d_chan),
		.shift   (shift),
		.result  (result),
		.strobe  (strobe),
		.chan    (chan),
		.clip    (clip)
	);

endmodule

/* testbench/cic_tb.sv */
// testbench for the four-channel CIC decimator
// directed tests checked against the constant-input gain model

`timescale 1ns/1ps

module cic_tb
	import cic_data_pkg::*;
	import cic_ctrl_pkg::*;
();

	// DUT ports
	logic             clk;
	logic             rst_n;
	adc_t [nchan-1:0] adc_data;
	period_t          period;
	shift_t           shift;
	res_t             result;
	chan_t            chan;
	logic             strobe;
	logic             clip;

	// per-channel inputs and settings now applied to the DUT
	int xin [nchan];
	int cur_period;
	int cur_shift;

	// results of the last captured burst, by channel
	int got [nchan];

	integer seed;

	cic_top i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.adc_data (adc_data),
		.period   (period),
		.shift    (shift),
		.result   (result),
		.chan     (chan),
		.strobe   (strobe),
		.clip     (clip)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// prints the cause and ends the run as failed
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	// steady-state output for a constant input is x * p^2 shifted and then clamped
	function automatic int expect_result(input int x, input int p, input int sh);
		longint v;
		longint lim;
		lim = longint'(1) << (out_w - 1);
		v   = longint'(x) * p * p;
		v   = v >>> (sh + int'(shift_base));
		if (v > lim - 1) begin
			v = lim - 1;
		end else if (v < -lim) begin
			v = -lim;
		end
		return int'(v);
	endfunction

	// new inputs, period and shift, all on one rising edge
	task automatic apply_settings(input int p, input int sh);
		@(posedge clk);
		period <= period_t'(p);
		shift  <= shift_t'(sh);
		for (int i = 0; i < nchan; i++) begin
			adc_data[i] <= adc_t'(xin[i]);
		end
		cur_period = p;
		cur_shift  = sh;
	endtask

	// a burst starts where strobe is high with channel 0
	task automatic wait_burst_start();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 200) begin
				abort_run("timeout: no burst appeared on the strobe output");
			end
		end while (!(strobe && chan == chan_t'(0)));
	endtask

	// skip bursts so the CIC transient and a period reload have passed
	task automatic skip_bursts(input int n);
		repeat (n) begin
			wait_burst_start();
		end
	endtask

	// collects one word per channel in the order 0 to 3
	task automatic capture_burst();
		wait_burst_start();
		got[0] = int'(result);
		for (int c = 1; c < nchan; c++) begin
			@(negedge clk);
			assert (strobe && chan == chan_t'(c)) else
				abort_run($sformatf("ERROR at %0t ns: strobe %0b chan %0d, expected chan %0d",
					$time, strobe, chan, c));
			got[c] = int'(result);
		end
	endtask

	// compare one burst with the gain model and the expected clip level
	task automatic check_burst(input bit clip_exp);
		int e;
		capture_burst();
		for (int c = 0; c < nchan; c++) begin
			e = expect_result(xin[c], cur_period, cur_shift);
			assert (got[c] == e) else
				abort_run($sformatf("ERROR at %0t ns: chan %0d result %0d, expected %0d",
					$time, c, got[c], e));
		end
		assert (clip == clip_exp) else
			abort_run($sformatf("ERROR at %0t ns: clip %0b, expected %0b", $time, clip, clip_exp));
	endtask

	task automatic test_reset();
		int n;
		// outputs stay quiet through the 10 reset edges
		for (int i = 0; i < 9; i++) begin
			@(negedge clk);
			assert (strobe === 1'b0 && clip === 1'b0) else
				abort_run($sformatf("ERROR at %0t ns: strobe or clip not low in reset", $time));
		end
		@(posedge clk);
		rst_n <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			assert (clip === 1'b0) else
				abort_run($sformatf("ERROR at %0t ns: clip set before the first burst", $time));
			if (n > 200) begin
				abort_run("timeout: no burst after reset was released");
			end
		end while (strobe !== 1'b1);
		assert (chan == chan_t'(0)) else
			abort_run($sformatf("ERROR at %0t ns: first burst starts at chan %0d", $time, chan));
	endtask

	task automatic test_burst();
		xin = '{500, -700, 1234, -4321};
		apply_settings(8, 0);
		wait_burst_start();
		// 4 cycles of strobe, 4 quiet, then the next burst
		for (int b = 0; b < 3; b++) begin
			for (int i = 1; i < 8; i++) begin
				@(negedge clk);
				if (i < nchan) begin
					assert (strobe && chan == chan_t'(i)) else
						abort_run($sformatf("ERROR at %0t ns: burst broken at chan %0d", $time, i));
				end else begin
					assert (!strobe) else
						abort_run($sformatf("ERROR at %0t ns: strobe high between bursts", $time));
				end
			end
			@(negedge clk);
			assert (strobe && chan == chan_t'(0)) else
				abort_run($sformatf("ERROR at %0t ns: burst did not repeat after 8 cycles", $time));
		end
		// the inputs have settled by now and the gain is 64
		check_burst(1'b0);
	endtask

	task automatic test_dc_gain();
		xin = '{1000, -2500, 30000, -123};
		// gain 256 and shift 6 give x * 4
		apply_settings(16, 6);
		skip_bursts(5);
		check_burst(1'b0);
		check_burst(1'b0);
	endtask

	task automatic test_shift();
		int shifts [4];
		shifts = '{4, 7, 10, 15};
		for (int s = 0; s < 4; s++) begin
			// moderate inputs stay in range for every shift here
			for (int c = 0; c < nchan; c++) begin
				xin[c] = $random(seed) % 2000;
			end
			apply_settings(16, shifts[s]);
			skip_bursts(5);
			check_burst(1'b0);
		end
	endtask

	task automatic test_saturation();
		// full scale positive on channel 0, negative on channel 1
		xin = '{(1 <<< (adc_w - 1)) - 1, -(1 <<< (adc_w - 1)), 100, -100};
		apply_settings(16, 0);
		skip_bursts(5);
		check_burst(1'b1);
		// clip must hold with in-range data
		xin = '{100, -100, 50, -50};
		apply_settings(16, 0);
		skip_bursts(5);
		check_burst(1'b1);
	endtask

	task automatic test_period_change();
		for (int c = 0; c < nchan; c++) begin
			xin[c] = $random(seed) % 50000;
		end
		// gain drops to 16 and bursts run back to back
		apply_settings(4, 2);
		skip_bursts(5);
		check_burst(1'b1);
		check_burst(1'b1);
	endtask

	initial begin
		seed       = 54857;
		rst_n      = 1'b0;
		adc_data   = '0;
		period     = period_t'(8);
		shift      = '0;
		xin        = '{default: 0};
		cur_period = 8;
		cur_shift  = 0;
		test_reset();
		test_burst();
		test_dc_gain();
		test_shift();
		test_saturation();
		test_period_change();
		$display("Test passed");
		$finish;
	end

endmodule

/* verilog.f */
design/cic_data_pkg.sv
design/cic_ctrl_pkg.sv
design/decim_timer.sv
design/double_integ.sv
design/chan_serializer.sv
design/double_diff.sv
design/post_scale.sv
design/cic_top.sv
testbench/cic_tb.sv

/* run.sh */
#!/bin/sh
# compile the CIC decimator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module cic_tb \
	&& ./obj_dir/Vcic_tb > sim.log 2>&1 \
	|| echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log 2>/dev/null && exit 0 || exit 1
